//--- testbench/vending_stimulus.txt
# op arg expected_a expected_b, arg and expected_b in hex, expected_a in decimal
# c coin total avail | s select total item | r lockout credit final | w - credit final
c 8 10 0
c 4 60 0
c 2 160 0
c 1 660 3
c 1 1160 7
c 1 1660 7
c F 2320 F
s 8 320 8
s 1 320 0
s 6 320 0
c 2 420 1
s 3 20 1
c 1 520 3
c 2 620 3
c 4 670 3
c 8 680 3
r 0 680 0
c 1 500 3
c F 1160 7
c F 1820 7
c F 2480 F
c F 3140 F
c F 3800 F
c F 4460 F
c 1 4960 F
c 4 4960 F
c 8 4970 F
c 2 4970 F
c 8 4980 F
s 4 3980 4
r 1 3980 0
c 2 100 0
c 4 150 0
w 0 150 0

//--- sim.f
verilog/vending_pkg.sv
verilog/ledger_if.sv
verilog/credit_ledger.sv
verilog/item_gate.sv
verilog/change_unit.sv
verilog/vend_control.sv
verilog/vending_top.sv
testbench/vending_assert.sv
testbench/tb_vending.sv

//--- run_sim.sh
#!/bin/sh
# build and run the vending machine testbench with Verilator
set -e
cd "$(dirname "$0")"

rm -rf obj_dir
verilator --binary --timing --assert --top-module tb_vending -f sim.f

# keep running after an assertion error so the testbench can report it
if ! ./obj_dir/Vtb_vending +verilator+error+limit+1000 > sim.log 2>&1; then
	cat sim.log
	echo "simulation aborted"
	exit 1
fi
cat sim.log

if grep -q "Some tests failed" sim.log; then
	exit 1
fi
exit 0

//--- testbench/tb_vending.sv
`timescale 1ns/1ns
`default_nettype none

module tb_vending;
	import vending_pkg::*;

	localparam int WAIT_CYCLES    = 20;
	localparam int HALF_PERIOD    = 4;
	localparam int RETURN_TIMEOUT = 200;

	// coin values in coin mask order with the largest first
	localparam int DENOM [4] = '{500, 100, 50, 10};

	logic       clk;
	logic       i_arst_n;
	coin_mask_t i_input_coin;
	item_mask_t i_select_item;
	logic       i_trigger_return;
	item_mask_t o_available_item;
	item_mask_t o_output_item;
	coin_mask_t o_return_coin;
	total_t     o_current_total;
	logic       o_returning;

	int error_count = 0;
	int check_count = 0;
	int test_count = 0;
	int cycle_count = 0;
	int last_strobe_cycle = 0;

	vending_top #(
		.WAIT_CYCLES (WAIT_CYCLES)
	) u_dut (
		.clk              (clk),
		.i_arst_n         (i_arst_n),
		.i_input_coin     (i_input_coin),
		.i_select_item    (i_select_item),
		.i_trigger_return (i_trigger_return),
		.o_available_item (o_available_item),
		.o_output_item    (o_output_item),
		.o_return_coin    (o_return_coin),
		.o_current_total  (o_current_total),
		.o_returning      (o_returning)
	);

	initial begin
		clk = 1'b0;
		forever #HALF_PERIOD clk = ~clk;
	end

	always @(posedge clk) cycle_count <= cycle_count + 1;

	task automatic check_value(input string name, input logic [31:0] got,
			input logic [31:0] expected);
		check_count++;
		if (got !== expected) begin
			error_count++;
			$display("ERR t=%0t %s got %0d expected %0d", $time, name, got, expected);
		end
	endtask

	// greedy pick from the remaining credit with one coin per denomination
	function automatic logic [3:0] greedy_mask(input int remainder);
		logic [3:0] mask;
		int         rem;
		mask = '0;
		rem = remainder;
		for (int i = 0; i < 4; i++) begin
			if (DENOM[i] <= rem) begin
				mask[i] = 1'b1;
				rem -= DENOM[i];
			end
		end
		return mask;
	endfunction

	function automatic int mask_value(input logic [3:0] mask);
		int sum;
		sum = 0;
		for (int i = 0; i < 4; i++) begin
			if (mask[i])
				sum += DENOM[i];
		end
		return sum;
	endfunction

	// inputs change 1 ns after the rising edge
	task automatic step_cycle();
		@(posedge clk);
		#1;
	endtask

	task automatic insert_coin(input logic [31:0] coin, input logic [31:0] exp_total,
			input logic [31:0] exp_avail);
		i_input_coin = coin_mask_t'(coin);
		step_cycle();
		last_strobe_cycle = cycle_count;
		i_input_coin = '0;
		check_value("o_current_total", 32'(o_current_total), exp_total);
		check_value("o_available_item", 32'(o_available_item), exp_avail);
	endtask

	task automatic select_item(input logic [31:0] sel, input logic [31:0] exp_total,
			input logic [31:0] exp_item);
		i_select_item = item_mask_t'(sel);
		step_cycle();
		last_strobe_cycle = cycle_count;
		i_select_item = '0;
		check_value("o_output_item", 32'(o_output_item), exp_item);
		check_value("o_current_total", 32'(o_current_total), exp_total);
		step_cycle();
		// the dispense pulse lasts a single cycle
		check_value("o_output_item", 32'(o_output_item), 0);
	endtask

	// follows the coin masks until o_returning falls
	task automatic collect_change(input int credit, input logic lockout, input int exp_final);
		int         remaining;
		int         returned;
		int         cycles;
		logic [3:0] expected;
		remaining = credit;
		returned = 0;
		cycles = 0;
		check_value("o_return_coin", 32'(o_return_coin), 0);
		while (o_returning && cycles < RETURN_TIMEOUT) begin
			if (lockout) begin
				i_input_coin = 4'b0001;
				i_select_item = 4'b0001;
			end
			step_cycle();
			cycles++;
			expected = greedy_mask(remaining);
			check_value("o_return_coin", 32'(o_return_coin), 32'(expected));
			remaining -= mask_value(expected);
			returned += mask_value(o_return_coin);
			check_value("o_current_total", 32'(o_current_total), remaining);
			check_value("o_output_item", 32'(o_output_item), 0);
		end
		i_input_coin = '0;
		i_select_item = '0;
		if (o_returning) begin
			error_count++;
			$display("o_returning still high after %0d cycles of change return", cycles);
		end
		check_value("returned coin sum", returned, credit);
		check_value("o_current_total", 32'(o_current_total), exp_final);
	endtask

	task automatic trigger_return(input logic lockout, input int credit, input int exp_final);
		i_trigger_return = 1'b1;
		step_cycle();
		i_trigger_return = 1'b0;
		check_value("o_returning", 32'(o_returning), 1);
		collect_change(credit, lockout, exp_final);
	endtask

	task automatic await_timeout(input int credit, input int exp_final);
		int waited;
		waited = 0;
		while (!o_returning && waited < RETURN_TIMEOUT) begin
			step_cycle();
			waited++;
		end
		if (!o_returning) begin
			error_count++;
			$display("o_returning never rose while credit was left idle");
		end else if (cycle_count - last_strobe_cycle < WAIT_CYCLES) begin
			error_count++;
			$display("change return started after only %0d idle cycles",
				cycle_count - last_strobe_cycle);
		end
		collect_change(credit, 1'b0, exp_final);
	endtask

	initial begin
		int          fd;
		int          gap;
		int          fields;
		int          errors_before;
		string       line;
		byte         op;
		logic [31:0] arg;
		logic [31:0] exp_a;
		logic [31:0] exp_b;
		i_arst_n = 1'b0;
		i_input_coin = '0;
		i_select_item = '0;
		i_trigger_return = 1'b0;
		void'($urandom(43524));
		repeat (2) @(posedge clk);
		#1;
		i_arst_n = 1'b1;

		test_count++;
		errors_before = error_count;
		check_value("o_current_total", 32'(o_current_total), 0);
		check_value("o_returning", 32'(o_returning), 0);
		check_value("o_return_coin", 32'(o_return_coin), 0);
		check_value("o_output_item", 32'(o_output_item), 0);
		$display("test %0d reset: %s", test_count, (error_count == errors_before) ? "ok" : "FAIL");

		fd = $fopen("testbench/vending_stimulus.txt", "r");
		if (fd == 0) begin
			error_count++;
			$display("could not open testbench/vending_stimulus.txt");
		end else begin
			while (!$feof(fd)) begin
				line = "";
				void'($fgets(line, fd));
				if (line.len() == 0 || line[0] == "#")
					continue;
				fields = $sscanf(line, "%c %h %d %h", op, arg, exp_a, exp_b);
				if (fields != 4)
					continue;
				test_count++;
				errors_before = error_count;
				// short idle gap well below the inactivity timeout
				gap = $urandom_range(3, 0);
				repeat (gap) step_cycle();
				case (op)
					"c": insert_coin(arg, exp_a, exp_b);
					"s": select_item(arg, exp_a, exp_b);
					"r": trigger_return(arg != 0, exp_a, exp_b);
					"w": await_timeout(exp_a, exp_b);
					default: begin
						error_count++;
						$display("unknown operation %c in the stimulus file", op);
					end
				endcase
				$display("test %0d op %c arg %0h: %s", test_count, op, arg,
					(error_count == errors_before) ? "ok" : "FAIL");
			end
			$fclose(fd);
		end

		$display("tests %0d, checks %0d, errors %0d, assertion failures %0d",
			test_count, check_count, error_count,
			u_dut.u_vending_assert.item_failures + u_dut.u_vending_assert.coin_failures
			+ u_dut.u_vending_assert.total_failures);
		if (error_count == 0 && u_dut.u_vending_assert.item_failures == 0
				&& u_dut.u_vending_assert.coin_failures == 0
				&& u_dut.u_vending_assert.total_failures == 0) begin
			$display("All tests passed");
		end else begin
			$display("Some tests failed");
		end
		$finish;
	end

endmodule

`default_nettype wire

//--- testbench/vending_assert.sv
`timescale 1ns/1ns
`default_nettype none

module vending_assert (
	input wire                     clk,
	input wire                     i_arst_n,
	input vending_pkg::item_mask_t i_output_item,
	input vending_pkg::coin_mask_t i_return_coin,
	input vending_pkg::total_t     i_current_total,
	input wire                     i_returning
);
	import vending_pkg::*;

	int unsigned item_failures = 0;
	int unsigned coin_failures = 0;
	int unsigned total_failures = 0;

	// at most one item leaves per pulse
	a_item_onehot: assert property (@(posedge clk) disable iff (!i_arst_n)
		$onehot0(i_output_item))
		else begin
			item_failures++;
			$error("o_output_item %b is not one-hot", i_output_item);
		end

	// coins only come out during change return
	a_coin_idle: assert property (@(posedge clk) disable iff (!i_arst_n)
		!i_returning |-> (i_return_coin == '0))
		else begin
			coin_failures++;
			$error("o_return_coin %b while not returning", i_return_coin);
		end

	a_total_max: assert property (@(posedge clk) disable iff (!i_arst_n)
		i_current_total <= TOTAL_MAX)
		else begin
			total_failures++;
			$error("o_current_total %0d above the credit ceiling", i_current_total);
		end

endmodule

bind vending_top vending_assert u_vending_assert (
	.clk             (clk),
	.i_arst_n        (i_arst_n),
	.i_output_item   (o_output_item),
	.i_return_coin   (o_return_coin),
	.i_current_total (o_current_total),
	.i_returning     (o_returning)
);

`default_nettype wire

//--- verilog/vending_top.sv
`timescale 1ns/1ns
`default_nettype none

module vending_top #(
	parameter int WAIT_CYCLES = 100
) (
	input  wire                     clk,
	input  wire                     i_arst_n,
	input  vending_pkg::coin_mask_t i_input_coin,
	input  vending_pkg::item_mask_t i_select_item,
	input  wire                     i_trigger_return,
	output vending_pkg::item_mask_t o_available_item,
	output vending_pkg::item_mask_t o_output_item,
	output vending_pkg::coin_mask_t o_return_coin,
	output vending_pkg::total_t     o_current_total,
	output logic                    o_returning
);

	ledger_if lg ();

	credit_ledger u_credit_ledger (
		.clk          (clk),
		.i_arst_n     (i_arst_n),
		.i_input_coin (i_input_coin),
		.lg           (lg.ledger)
	);

	item_gate u_item_gate (
		.clk              (clk),
		.i_arst_n         (i_arst_n),
		.i_select_item    (i_select_item),
		.o_available_item (o_available_item),
		.o_output_item    (o_output_item),
		.lg               (lg.gate)
	);

	change_unit u_change_unit (
		.clk           (clk),
		.i_arst_n      (i_arst_n),
		.o_return_coin (o_return_coin),
		.lg            (lg.changer)
	);

	vend_control #(
		.WAIT_CYCLES (WAIT_CYCLES)
	) u_vend_control (
		.clk              (clk),
		.i_arst_n         (i_arst_n),
		.i_input_coin     (i_input_coin),
		.i_select_item    (i_select_item),
		.i_trigger_return (i_trigger_return),
		.o_returning      (o_returning),
		.lg               (lg.control)
	);

	// registered credit straight from the ledger
	assign o_current_total = lg.total;

endmodule

`default_nettype wire

//--- verilog/vend_control.sv
`timescale 1ns/1ns
`default_nettype none

module vend_control #(
	parameter int WAIT_CYCLES = 100
) (
	input  wire                     clk,
	input  wire                     i_arst_n,
	input  vending_pkg::coin_mask_t i_input_coin,
	input  vending_pkg::item_mask_t i_select_item,
	input  wire                     i_trigger_return,
	output logic                    o_returning,
	ledger_if.control               lg
);
	import vending_pkg::*;

	// loaded with one less so the count spans exactly WAIT_CYCLES edges
	localparam wait_t RELOAD = wait_t'(WAIT_CYCLES - 1);

	ctrl_state_t state_q;
	ctrl_state_t state_d;
	wait_t       wait_q;
	logic        strobe;
	logic        timeout;
	logic        returning;

	assign strobe = (|i_input_coin) | (|i_select_item);

	// idle too long with credit held
	assign timeout = (wait_q == '0) && (lg.total != '0) && !strobe;

	always_comb begin
		state_d = state_q;
		case (state_q)
			ST_IDLE: begin
				if (i_trigger_return || timeout)
					state_d = ST_RETURN;
			end
			ST_RETURN: begin
				// leave one cycle after the last coin has gone out
				if (lg.total == '0)
					state_d = ST_IDLE;
			end
		endcase
	end

	always_ff @(posedge clk or negedge i_arst_n) begin
		if (!i_arst_n) begin
			state_q <= ST_IDLE;
		end else begin
			state_q <= state_d;
		end
	end

	// inactivity countdown that only runs in idle with nonzero credit
	always_ff @(posedge clk or negedge i_arst_n) begin
		if (!i_arst_n) begin
			wait_q <= RELOAD;
		end else if (state_q != ST_IDLE || strobe || lg.total == '0) begin
			wait_q <= RELOAD;
		end else if (wait_q != '0) begin
			wait_q <= wait_q - wait_t'(1);
		end
	end

	assign returning    = (state_q == ST_RETURN);
	assign lg.returning = returning;
	assign o_returning  = returning;

endmodule

`default_nettype wire

//--- verilog/change_unit.sv
`timescale 1ns/1ns
`default_nettype none

module change_unit (
	input  wire                     clk,
	input  wire                     i_arst_n,
	output vending_pkg::coin_mask_t o_return_coin,
	ledger_if.changer               lg
);
	import vending_pkg::*;

	coin_mask_t greedy_mask;
	total_t     change_cost;

	// greedy pick with at most one coin of each denomination per cycle
	always_comb begin
		total_t rem;
		rem = lg.total;
		greedy_mask = '0;
		for (int i = 0; i < NUM_COINS; i++) begin
			if (COIN_VALUE[i] <= rem) begin
				greedy_mask[i] = 1'b1;
				rem = rem - COIN_VALUE[i];
			end
		end
		if (!lg.returning)
			greedy_mask = '0;
	end

	// deducted on the same edge that registers the mask
	assign change_cost = coin_mask_value(greedy_mask);
	assign lg.change_cost = change_cost;

	always_ff @(posedge clk or negedge i_arst_n) begin
		if (!i_arst_n) begin
			o_return_coin <= '0;
		end else begin
			o_return_coin <= greedy_mask;
		end
	end

endmodule

`default_nettype wire

//--- verilog/item_gate.sv
`timescale 1ns/1ns
`default_nettype none

module item_gate (
	input  wire                     clk,
	input  wire                     i_arst_n,
	input  vending_pkg::item_mask_t i_select_item,
	output vending_pkg::item_mask_t o_available_item,
	output vending_pkg::item_mask_t o_output_item,
	ledger_if.gate                  lg
);
	import vending_pkg::*;

	item_mask_t lowest_sel;
	item_mask_t dispense;
	total_t     item_cost;

	// an item is offered when the credit covers its price
	always_comb begin
		for (int i = 0; i < NUM_ITEMS; i++) begin
			o_available_item[i] = (lg.total >= ITEM_PRICE[i]);
		end
	end

	// isolate the lowest set select bit
	assign lowest_sel = i_select_item & (~i_select_item + item_mask_t'(1));

	// no dispensing while change is going out
	assign dispense = lg.returning ? '0 : (lowest_sel & o_available_item);

	always_comb begin
		item_cost = '0;
		for (int i = 0; i < NUM_ITEMS; i++) begin
			if (dispense[i])
				item_cost = ITEM_PRICE[i];
		end
	end

	assign lg.item_cost = item_cost;

	// one-cycle dispense pulse on the same edge as the deduction
	always_ff @(posedge clk or negedge i_arst_n) begin
		if (!i_arst_n) begin
			o_output_item <= '0;
		end else begin
			o_output_item <= dispense;
		end
	end

endmodule

`default_nettype wire

//--- verilog/credit_ledger.sv
`timescale 1ns/1ns
`default_nettype none

module credit_ledger (
	input  wire                     clk,
	input  wire                     i_arst_n,
	input  vending_pkg::coin_mask_t i_input_coin,
	ledger_if.ledger                lg
);
	import vending_pkg::*;

	total_t total_q;
	total_t deposit;
	total_t credited;
	logic   accept;

	// value of the coins strobed this cycle
	assign deposit = coin_mask_value(i_input_coin);

	// refuse coins during change return and anything past the ceiling
	assign accept = !lg.returning && ((total_q + deposit) <= TOTAL_MAX);

	assign credited = accept ? (total_q + deposit) : total_q;

	// item and change costs are never both nonzero
	// since item_gate is locked out while returning
	always_ff @(posedge clk or negedge i_arst_n) begin
		if (!i_arst_n) begin
			total_q <= '0;
		end else begin
			total_q <= credited - lg.item_cost - lg.change_cost;
		end
	end

	assign lg.total = total_q;

endmodule

`default_nettype wire

//--- verilog/ledger_if.sv
`timescale 1ns/1ns
`default_nettype none

interface ledger_if;
	import vending_pkg::*;

	total_t total;
	total_t item_cost;
	total_t change_cost;
	logic   returning;

	modport ledger (output total, input item_cost, input change_cost, input returning);

	modport gate (output item_cost, input total, input returning);

	modport changer (output change_cost, input total, input returning);

	// the controller only watches the credit and owns the return flag
	modport control (output returning, input total);

endinterface

`default_nettype wire

//--- verilog/vending_pkg.sv
`default_nettype none

package vending_pkg;

	localparam int NUM_COINS  = 4;
	localparam int NUM_ITEMS  = 4;
	localparam int TOTAL_BITS = 16;

	// coin bits run from the largest denomination down
	typedef logic [NUM_COINS-1:0]  coin_mask_t;
	typedef logic [NUM_ITEMS-1:0]  item_mask_t;
	typedef logic [TOTAL_BITS-1:0] total_t;
	typedef logic [15:0]           wait_t;

	localparam total_t COIN_VALUE [NUM_COINS] = '{16'd500, 16'd100, 16'd50, 16'd10};
	localparam total_t ITEM_PRICE [NUM_ITEMS] = '{16'd400, 16'd500, 16'd1000, 16'd2000};

	// coins that would push the credit past this ceiling are refused
	localparam total_t TOTAL_MAX = 16'd5000;

	typedef enum logic [0:0] {
		ST_IDLE,
		ST_RETURN
	} ctrl_state_t;

	// sum of the denominations flagged in a coin mask
	function automatic total_t coin_mask_value(input coin_mask_t mask);
		total_t sum;
		sum = '0;
		for (int i = 0; i < NUM_COINS; i++) begin
			if (mask[i])
				sum = sum + COIN_VALUE[i];
		end
		return sum;
	endfunction

endpackage

`default_nettype wire
